//--- source/adc_src_config.svh
// Build-time sizing and register map of the ADC test-pattern source.
// Included by the package and by every RTL module that needs a width or offset.
`ifndef ADC_SRC_CONFIG_SVH
`define ADC_SRC_CONFIG_SVH

// ---------------------------------------------------------
// datapath sizing
// ---------------------------------------------------------
`define ADC_SRC_NUM_SLICES 4        // slices in the one tile
`define ADC_SRC_SAMPLE_W   12       // useable adc sample bits
`define ADC_SRC_DIV_W      16       // clock divider counter

// ---------------------------------------------------------
// wishbone classic bus
// ---------------------------------------------------------
`define ADC_SRC_WB_ADR_W   8        // word address
`define ADC_SRC_WB_DAT_W   32       // data bus

// ---------------------------------------------------------
// register map, word offsets inside a slice block
// ---------------------------------------------------------
`define ADC_SRC_REG_CTRL   2'd0     // enable and pattern type
`define ADC_SRC_REG_INIT   2'd1     // first sample value
`define ADC_SRC_REG_INC    2'd2     // ramp step
`define ADC_SRC_REG_DIV    2'd3     // sample spacing minus one
`define ADC_SRC_REG_GLOBAL 16       // global enable word

`endif

//--- source/adc_src_pkg.sv
// Shared types of the ADC test-pattern source.
// Modules import it inside their bodies and name its types in port lists.
`default_nettype none

`include "adc_src_config.svh"

package adc_src_pkg;

   // ---------------------------------------------------------
   // pattern select
   // ---------------------------------------------------------
   // value 3 is not named and behaves as constant
   typedef enum logic [1:0] {
      dg_const  = 2'd0,          // hold init
      dg_ramp   = 2'd1,          // add inc per sample
      dg_toggle = 2'd2           // invert all bits per sample
   } dg_type_e;

   // ---------------------------------------------------------
   // per-slice configuration, bank to generator
   // ---------------------------------------------------------
   typedef struct packed {
      logic                         run;      // slice enable and global enable
      dg_type_e                     dg_type;  // pattern select
      logic [`ADC_SRC_SAMPLE_W-1:0] init;     // first sample
      logic [`ADC_SRC_SAMPLE_W-1:0] inc;      // ramp step
      logic [`ADC_SRC_DIV_W-1:0]    div;      // spacing is div+1 cycles
   } slice_cfg_t;

   // ---------------------------------------------------------
   // one sample of the output stream
   // ---------------------------------------------------------
   // no ready, the stream never stalls
   typedef struct packed {
      logic                         valid;    // one cycle per sample
      logic [`ADC_SRC_SAMPLE_W-1:0] data;     // zero while stopped
   } adc_sample_t;

endpackage

`default_nettype wire

//--- source/wb_reg_bank.sv
// Wishbone classic register bank for the four pattern slices.
// Holds ctrl, init, inc and div per slice plus the global enable, answers every
// request with a one-cycle ack and feeds each slice a registered run bit.
`timescale 1ns/100ps
`default_nettype none

`include "adc_src_config.svh"

module wb_reg_bank (
   input  logic                           adc_fab_clk,
   input  logic                           rst_n,
   input  logic                           wb_cyc,
   input  logic                           wb_stb,
   input  logic                           wb_we,
   input  logic [`ADC_SRC_WB_ADR_W-1:0]   wb_adr,
   input  logic [`ADC_SRC_WB_DAT_W-1:0]   wb_dat_w,
   output logic [`ADC_SRC_WB_DAT_W-1:0]   wb_dat_r,
   output logic                           wb_ack,
   output adc_src_pkg::slice_cfg_t        cfg [`ADC_SRC_NUM_SLICES]
);

   import adc_src_pkg::*;

   localparam int SLICE_BITS = $clog2(`ADC_SRC_NUM_SLICES);
   localparam logic [`ADC_SRC_WB_ADR_W-1:0] BLOCK_END =
      `ADC_SRC_WB_ADR_W'(`ADC_SRC_NUM_SLICES * 4);             // first word past slices
   localparam logic [`ADC_SRC_WB_ADR_W-1:0] GLOBAL_ADR =
      `ADC_SRC_WB_ADR_W'(`ADC_SRC_REG_GLOBAL);

   // ---------------------------------------------------------
   // field registers
   // ---------------------------------------------------------
   logic                         en_q     [`ADC_SRC_NUM_SLICES];   // slice enable
   dg_type_e                     type_q   [`ADC_SRC_NUM_SLICES];
   logic [`ADC_SRC_SAMPLE_W-1:0] init_q   [`ADC_SRC_NUM_SLICES];
   logic [`ADC_SRC_SAMPLE_W-1:0] inc_q    [`ADC_SRC_NUM_SLICES];
   logic [`ADC_SRC_DIV_W-1:0]    div_q    [`ADC_SRC_NUM_SLICES];
   logic                         run_q    [`ADC_SRC_NUM_SLICES];   // en & global, one cycle late
   logic                         global_q;                        // gates every slice

   logic                         req;         // new request this cycle
   logic                         wr_stb;      // write on this edge
   logic                         in_block;    // address hits a slice block
   logic                         is_global;
   logic [SLICE_BITS-1:0]        sel_slice;
   logic [1:0]                   sel_reg;
   logic [`ADC_SRC_WB_DAT_W-1:0] rd_data;

   // ---------------------------------------------------------
   // address decode
   // ---------------------------------------------------------
   assign req       = wb_cyc & wb_stb & ~wb_ack;   // no ack twice in a row
   assign wr_stb    = req & wb_we;
   assign in_block  = (wb_adr < BLOCK_END);
   assign is_global = (wb_adr == GLOBAL_ADR);
   assign sel_slice = wb_adr[SLICE_BITS+1:2];      // four words per slice
   assign sel_reg   = wb_adr[1:0];

   // readback mux, unused bits and unmapped words stay zero
   always_comb begin
      rd_data = '0;
      if (in_block) begin
         case (sel_reg)
            `ADC_SRC_REG_CTRL: rd_data[2:0] = {type_q[sel_slice], en_q[sel_slice]};
            `ADC_SRC_REG_INIT: rd_data[`ADC_SRC_SAMPLE_W-1:0] = init_q[sel_slice];
            `ADC_SRC_REG_INC:  rd_data[`ADC_SRC_SAMPLE_W-1:0] = inc_q[sel_slice];
            default:           rd_data[`ADC_SRC_DIV_W-1:0] = div_q[sel_slice];
         endcase
      end else if (is_global) begin
         rd_data[0] = global_q;
      end
   end

   // ---------------------------------------------------------
   // ack, writes and run bits
   // ---------------------------------------------------------
   always_ff @(posedge adc_fab_clk) begin
      if (!rst_n) begin
         wb_ack   <= 1'b0;
         global_q <= 1'b0;
         for (int s = 0; s < `ADC_SRC_NUM_SLICES; s++) begin
            en_q[s]   <= 1'b0;
            type_q[s] <= dg_const;
            init_q[s] <= '0;
            inc_q[s]  <= '0;
            div_q[s]  <= '0;
            run_q[s]  <= 1'b0;
         end
      end else begin
         wb_ack <= req;                              // write lands on the ack edge
         if (wr_stb && is_global) begin
            global_q <= wb_dat_w[0];
         end
         for (int s = 0; s < `ADC_SRC_NUM_SLICES; s++) begin
            run_q[s] <= en_q[s] & global_q;          // costs one cycle of latency
            if (wr_stb && in_block && sel_slice == SLICE_BITS'(s)) begin
               case (sel_reg)
                  `ADC_SRC_REG_CTRL: begin
                     en_q[s]   <= wb_dat_w[0];
                     type_q[s] <= dg_type_e'(wb_dat_w[2:1]);
                  end
                  `ADC_SRC_REG_INIT: init_q[s] <= wb_dat_w[`ADC_SRC_SAMPLE_W-1:0];
                  `ADC_SRC_REG_INC:  inc_q[s]  <= wb_dat_w[`ADC_SRC_SAMPLE_W-1:0];
                  default:           div_q[s]  <= wb_dat_w[`ADC_SRC_DIV_W-1:0];
               endcase
            end
         end
      end
   end

   // read data captured with the ack, held until the next request
   always_ff @(posedge adc_fab_clk) begin
      if (req) begin
         wb_dat_r <= rd_data;
      end
   end

   // ---------------------------------------------------------
   // config out to the slices
   // ---------------------------------------------------------
   always_comb begin
      for (int s = 0; s < `ADC_SRC_NUM_SLICES; s++) begin
         cfg[s].run     = run_q[s];
         cfg[s].dg_type = type_q[s];
         cfg[s].init    = init_q[s];
         cfg[s].inc     = inc_q[s];
         cfg[s].div     = div_q[s];
      end
   end

   // ---------------------------------------------------------
   // bus protocol checks
   // ---------------------------------------------------------
   // ack answers a request seen on the previous edge
   a_ack_after_req: assert property (@(posedge adc_fab_clk) disable iff (!rst_n)
      wb_ack |-> $past(wb_cyc & wb_stb));

   // single-cycle ack, master has time to drop stb
   a_ack_single: assert property (@(posedge adc_fab_clk) disable iff (!rst_n)
      wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

//--- source/dg_slice.sv
// One slice data generator of the ADC test-pattern source.
// A divider counter paces the samples, the pattern engine produces constant,
// ramp or toggle data starting from init, the output register drives the stream.
`timescale 1ns/100ps
`default_nettype none

`include "adc_src_config.svh"

module dg_slice (
   input  logic                     adc_fab_clk,
   input  logic                     rst_n,
   input  adc_src_pkg::slice_cfg_t  cfg,
   output adc_src_pkg::adc_sample_t sample
);

   import adc_src_pkg::*;

   logic [`ADC_SRC_DIV_W-1:0]    cnt;      // 0 .. div
   logic                         run_d;    // run seen on the last edge
   logic                         tick;     // emit a sample on this edge
   logic                         start;    // first edge with run high
   logic [`ADC_SRC_SAMPLE_W-1:0] pat;      // next sample to emit
   logic [`ADC_SRC_SAMPLE_W-1:0] cur;      // sample emitted on a tick
   logic [`ADC_SRC_SAMPLE_W-1:0] nxt;      // value after cur

   // ---------------------------------------------------------
   // divider
   // ---------------------------------------------------------
   // the counter starts at zero on the start edge, so the first
   // tick lands div+1 cycles after run went high
   assign tick  = cfg.run && (cnt == cfg.div);
   assign start = cfg.run & ~run_d;

   always_ff @(posedge adc_fab_clk) begin
      if (!rst_n) begin
         cnt   <= '0;
         run_d <= 1'b0;
      end else begin
         run_d <= cfg.run;
         if (!cfg.run || tick) begin
            cnt <= '0;                        // wrap or hold while stopped
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // ---------------------------------------------------------
   // pattern engine
   // ---------------------------------------------------------
   // on the start edge init bypasses the pattern register, which
   // covers div = 0 where start and the first tick coincide
   assign cur = start ? cfg.init : pat;

   always_comb begin
      case (cfg.dg_type)
         dg_ramp:   nxt = cur + cfg.inc;      // wraps mod 4096
         dg_toggle: nxt = ~cur;               // all 12 bits flip
         default:   nxt = cur;                // constant, also code 3
      endcase
   end

   always_ff @(posedge adc_fab_clk) begin
      if (tick) begin
         pat <= nxt;                          // step once per sample
      end else if (start) begin
         pat <= cfg.init;                     // restart from init
      end
   end

   // ---------------------------------------------------------
   // output register
   // ---------------------------------------------------------
   always_ff @(posedge adc_fab_clk) begin
      if (!rst_n) begin
         sample <= '0;
      end else if (!cfg.run) begin
         sample <= '0;                        // stopped, quiet bus
      end else begin
         sample.valid <= tick;                // one cycle per sample
         if (tick) begin
            sample.data <= cur;               // data held between ticks
         end
      end
   end

   // ---------------------------------------------------------
   // checks
   // ---------------------------------------------------------
   // stopping takes effect on the very next edge, with no tail sample
   a_stopped_quiet: assert property (@(posedge adc_fab_clk) disable iff (!rst_n)
      !cfg.run |=> !sample.valid);

endmodule

`default_nettype wire

//--- source/adc_src_top.sv
// Top level of the ADC test-pattern source for one four-slice tile.
// The Wishbone bank configures the slices, each slice drives one sample stream.
`timescale 1ns/100ps
`default_nettype none

`include "adc_src_config.svh"

module adc_src_top (
   input  logic                           adc_fab_clk,   // fabric and bus clock
   input  logic                           rst_n,
   input  logic                           wb_cyc,
   input  logic                           wb_stb,
   input  logic                           wb_we,
   input  logic [`ADC_SRC_WB_ADR_W-1:0]   wb_adr,        // word address
   input  logic [`ADC_SRC_WB_DAT_W-1:0]   wb_dat_w,
   output logic [`ADC_SRC_WB_DAT_W-1:0]   wb_dat_r,
   output logic                           wb_ack,
   output adc_src_pkg::adc_sample_t       samples [`ADC_SRC_NUM_SLICES]
);

   import adc_src_pkg::*;

   slice_cfg_t cfg [`ADC_SRC_NUM_SLICES];                // bank to slices

   // ---------------------------------------------------------
   // control register bank
   // ---------------------------------------------------------
   wb_reg_bank u_reg_bank (
      .adc_fab_clk (adc_fab_clk),
      .rst_n       (rst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .cfg         (cfg)
   );

   // ---------------------------------------------------------
   // slice data generators
   // ---------------------------------------------------------
   generate
      for (genvar g = 0; g < `ADC_SRC_NUM_SLICES; g++) begin : g_slice
         dg_slice u_slice (
            .adc_fab_clk (adc_fab_clk),
            .rst_n       (rst_n),
            .cfg         (cfg[g]),                      // slice g block of the map
            .sample      (samples[g])
         );
      end
   endgenerate

endmodule

`default_nettype wire

//--- tests/adc_src_tb.sv
// Testbench for the ADC test-pattern source.
// Drives the Wishbone bank, watches the four sample streams and checks reset,
// register readback, constant, ramp and toggle patterns and global gating.
`timescale 1ns/100ps
`default_nettype none

`include "adc_src_config.svh"

module adc_src_tb;

   import adc_src_pkg::*;

   localparam int  NS       = `ADC_SRC_NUM_SLICES;
   localparam real CLK_HALF = 2.0;                // 4 ns period
   localparam real DRV_DLY  = 0.5;                // drive and sample point after the edge
   // worst-case cycles of reset and of each test with bus ops at 3 cycles each
   localparam int  RUN_CYCLES = 4 + 60 + 170 + 40 + 60 + 70 + 60;
   localparam int  WATCHDOG_CYCLES = RUN_CYCLES * 2 + 200;

   logic                         adc_fab_clk;
   logic                         rst_n;
   logic                         wb_cyc;
   logic                         wb_stb;
   logic                         wb_we;
   logic [`ADC_SRC_WB_ADR_W-1:0] wb_adr;
   logic [`ADC_SRC_WB_DAT_W-1:0] wb_dat_w;
   logic [`ADC_SRC_WB_DAT_W-1:0] wb_dat_r;
   logic                         wb_ack;
   adc_sample_t                  samples [NS];

   logic [31:0] lfsr_q;                           // galois lfsr state
   int          err_cnt;
   int          test_err_base;                    // err_cnt when the test began
   int          pass_tests;
   int          fail_tests;
   string       cur_test;
   logic        gate_quiet;                       // streams must be silent
   logic        const_run;                        // slice 0 must stream init
   logic [11:0] const_init;
   logic        all_quiet;

   adc_src_top UUT (
      .adc_fab_clk (adc_fab_clk),
      .rst_n       (rst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .samples     (samples)
   );

   initial begin
      adc_fab_clk = 1'b0;
      forever #(CLK_HALF) adc_fab_clk = ~adc_fab_clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * 4.0);
      $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("sim failed");
      $finish;
   end

   // ------------------------------------------------------------
   // stream checks
   // ------------------------------------------------------------
   always_comb begin
      all_quiet = 1'b1;
      for (int s = 0; s < NS; s++) begin
         if (samples[s] != '0) all_quiet = 1'b0;   // valid or data left over
      end
   end

   a_gated_quiet: assert property (@(posedge adc_fab_clk) disable iff (!rst_n)
      gate_quiet |-> all_quiet)
   else begin
      $display("** Error: test %s: a stream is active while the global enable is off",
               cur_test);
      err_cnt++;
   end

   a_const_stream: assert property (@(posedge adc_fab_clk) disable iff (!rst_n)
      const_run |-> (samples[0].valid && samples[0].data == const_init))
   else begin
      $display("** Error: test %s: expected valid 1 data 0x%0h, actual valid %0b data 0x%0h",
               cur_test, const_init, samples[0].valid, samples[0].data);
      err_cnt++;
   end

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) n = n ^ 32'h8020_0003;            // x^32 + x^22 + x^2 + x + 1
      return n;
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r      = {r[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
      return r;
   endfunction

   function automatic int reg_adr(input int s, input int r);
      return 4 * s + r;                           // four words per slice
   endfunction

   // bits a register keeps by its offset in the slice block
   function automatic logic [31:0] field_mask(input int adr);
      case (adr % 4)
         0:       return 32'h0000_0007;           // type and enable
         1, 2:    return 32'h0000_0FFF;
         default: return 32'h0000_FFFF;
      endcase
   endfunction

   function automatic logic [31:0] ctrl_word(input logic en, input logic [1:0] t);
      return {29'd0, t, en};
   endfunction

   task automatic next_cycle();
      @(posedge adc_fab_clk);
      #(DRV_DLY);
   endtask

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("** Error: test %s, %s: expected 0x%0h, actual 0x%0h",
                  cur_test, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic wb_access(input int adr, input logic we, input logic [31:0] dat,
                            output logic [31:0] rd);
      int waited;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = 8'(adr);
      wb_dat_w = dat;
      waited   = 0;
      do begin
         next_cycle();
         waited++;
      end while (!wb_ack && waited < 16);
      if (!wb_ack) begin
         $display("** Error: test %s: no ack on bus access to word %0d", cur_test, adr);
         err_cnt++;
      end
      rd     = wb_dat_r;                          // valid while ack is high
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input int adr, input logic [31:0] dat);
      logic [31:0] unused;
      wb_access(adr, 1'b1, dat, unused);
   endtask

   task automatic wb_read(input int adr, output logic [31:0] dat);
      wb_access(adr, 1'b0, '0, dat);
   endtask

   // cycles until the slice shows valid or -1 if it never does
   task automatic wait_valid(input int s, input int max_cyc, output int lat);
      lat = 0;
      do begin
         next_cycle();
         lat++;
      end while (!samples[s].valid && lat < max_cyc);
      if (!samples[s].valid) begin
         $display("** Error: test %s: slice %0d gave no valid within %0d cycles",
                  cur_test, s, max_cyc);
         err_cnt++;
         lat = -1;
      end
   endtask

   task automatic begin_test(input string name);
      cur_test      = name;
      test_err_base = err_cnt;
   endtask

   task automatic end_test();
      if (err_cnt == test_err_base) begin
         pass_tests++;
         $display("test %s: ok", cur_test);
      end else begin
         fail_tests++;
         $display("test %s: FAIL with %0d errors", cur_test, err_cnt - test_err_base);
      end
   endtask

   // ------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------
   initial begin
      logic [31:0] rd;
      logic [31:0] wdat [16];
      logic [31:0] gdat;
      logic [11:0] r_init;
      logic [11:0] r_inc;
      logic [11:0] prev;
      logic [11:0] t_exp;
      logic [11:0] t_init [NS];
      int          t_div  [NS];
      int          seen   [NS];
      int          last   [NS];
      int          lat;

      rst_n      = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      gate_quiet = 1'b0;
      const_run  = 1'b0;
      const_init = '0;
      lfsr_q     = 32'd71362;                     // fixed seed
      err_cnt    = 0;
      pass_tests = 0;
      fail_tests = 0;
      cur_test   = "startup";
      repeat (4) @(posedge adc_fab_clk);
      #(DRV_DLY);
      rst_n = 1'b1;

      begin_test("reset");
      for (int s = 0; s < NS; s++) begin
         check_value($sformatf("slice %0d valid", s), 0, 32'(samples[s].valid));
         check_value($sformatf("slice %0d data", s), 0, 32'(samples[s].data));
      end
      for (int a = 0; a <= `ADC_SRC_REG_GLOBAL; a++) begin
         wb_read(a, rd);
         check_value($sformatf("word %0d", a), 0, rd);
      end
      end_test();

      begin_test("readback");
      for (int a = 0; a < 16; a++) begin
         wdat[a] = rand_bits(32);
         wb_write(a, wdat[a]);
      end
      gdat = rand_bits(32);
      wb_write(`ADC_SRC_REG_GLOBAL, gdat);
      wb_write(20, rand_bits(32));                // unmapped word
      for (int a = 0; a < 16; a++) begin
         wb_read(a, rd);
         check_value($sformatf("word %0d", a), wdat[a] & field_mask(a), rd);
      end
      wb_read(`ADC_SRC_REG_GLOBAL, rd);
      check_value("global word", gdat & 32'h1, rd);
      wb_read(20, rd);
      check_value("word 20", 0, rd);
      wb_write(`ADC_SRC_REG_GLOBAL, 0);           // stop everything first
      for (int a = 0; a < 16; a++) wb_write(a, 0);
      end_test();

      begin_test("constant");
      const_init = 12'(rand_bits(12));
      wb_write(reg_adr(0, `ADC_SRC_REG_INIT), 32'(const_init));
      wb_write(reg_adr(0, `ADC_SRC_REG_DIV), 0);
      wb_write(reg_adr(0, `ADC_SRC_REG_CTRL), ctrl_word(1'b1, 2'd0));
      wb_write(`ADC_SRC_REG_GLOBAL, 1);
      wait_valid(0, 20, lat);
      check_value("first valid latency", 2, 32'(lat));
      check_value("first data", 32'(const_init), 32'(samples[0].data));
      const_run = 1'b1;                           // valid every cycle from here
      repeat (10) next_cycle();
      const_run = 1'b0;
      wb_write(reg_adr(0, `ADC_SRC_REG_CTRL), 0);
      end_test();

      begin_test("ramp");
      r_init = 12'(rand_bits(12));
      r_inc  = 12'(rand_bits(12));
      wb_write(reg_adr(1, `ADC_SRC_REG_INIT), 32'(r_init));
      wb_write(reg_adr(1, `ADC_SRC_REG_INC), 32'(r_inc));
      wb_write(reg_adr(1, `ADC_SRC_REG_DIV), 3);
      wb_write(reg_adr(1, `ADC_SRC_REG_CTRL), ctrl_word(1'b1, 2'd1));
      wait_valid(1, 20, lat);
      check_value("first valid latency", 5, 32'(lat));   // div + 2
      check_value("first data", 32'(r_init), 32'(samples[1].data));
      prev = r_init;
      for (int k = 1; k <= 6; k++) begin
         wait_valid(1, 20, lat);
         check_value($sformatf("spacing %0d", k), 4, 32'(lat));
         prev = prev + r_inc;                                 // wraps mod 4096
         check_value($sformatf("sample %0d", k), 32'(prev), 32'(samples[1].data));
      end
      wb_write(reg_adr(1, `ADC_SRC_REG_CTRL), 0);
      end_test();

      begin_test("toggle");
      t_div[2] = 1;
      t_div[3] = 2;
      for (int s = 2; s < NS; s++) begin
         t_init[s] = 12'(rand_bits(12));
         seen[s]   = 0;
         last[s]   = 0;
         wb_write(reg_adr(s, `ADC_SRC_REG_INIT), 32'(t_init[s]));
         wb_write(reg_adr(s, `ADC_SRC_REG_DIV), 32'(t_div[s]));
      end
      wb_write(reg_adr(2, `ADC_SRC_REG_CTRL), ctrl_word(1'b1, 2'd2));
      wb_write(reg_adr(3, `ADC_SRC_REG_CTRL), ctrl_word(1'b1, 2'd2));
      for (int c = 1; c <= 40; c++) begin
         next_cycle();
         for (int s = 2; s < NS; s++) begin
            if (samples[s].valid) begin
               if (seen[s] > 0) begin
                  check_value($sformatf("slice %0d spacing", s), 32'(t_div[s] + 1),
                              32'(c - last[s]));
               end
               t_exp = (seen[s] % 2 == 0) ? t_init[s] : ~t_init[s];
               check_value($sformatf("slice %0d sample %0d", s, seen[s]),
                           32'(t_exp), 32'(samples[s].data));
               last[s] = c;
               seen[s]++;
            end
         end
      end
      for (int s = 2; s < NS; s++) begin
         assert (seen[s] >= 8) else begin
            $display("** Error: test %s: slice %0d gave only %0d samples",
                     cur_test, s, seen[s]);
            err_cnt++;
         end
      end
      end_test();

      begin_test("gating");
      t_init[0] = const_init;
      t_div[0]  = 0;
      wb_write(reg_adr(0, `ADC_SRC_REG_CTRL), ctrl_word(1'b1, 2'd0));
      wb_write(`ADC_SRC_REG_GLOBAL, 0);
      next_cycle();
      next_cycle();                               // second edge after the ack
      check_value("streams quiet", 1, 32'(all_quiet));
      gate_quiet = 1'b1;
      repeat (10) next_cycle();
      gate_quiet = 1'b0;
      wb_write(`ADC_SRC_REG_GLOBAL, 1);
      for (int s = 0; s < NS; s++) seen[s] = 0;
      for (int c = 1; c <= 20; c++) begin
         next_cycle();
         check_value("slice 1 valid", 0, 32'(samples[1].valid));   // slice 1 stays off
         for (int s = 0; s < NS; s++) begin
            if (s != 1 && samples[s].valid && seen[s] == 0) begin
               check_value($sformatf("slice %0d restart latency", s),
                           32'(t_div[s] + 2), 32'(c));
               check_value($sformatf("slice %0d restart data", s), 32'(t_init[s]),
                           32'(samples[s].data));
               seen[s] = 1;
            end
         end
      end
      for (int s = 0; s < NS; s++) begin
         if (s != 1) check_value($sformatf("slice %0d restarted", s), 1, 32'(seen[s]));
      end
      end_test();

      $display("tests: %0d ok, %0d failing, %0d errors", pass_tests, fail_tests, err_cnt);
      if (fail_tests == 0 && err_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+source
source/adc_src_pkg.sv
source/wb_reg_bank.sv
source/dg_slice.sv
source/adc_src_top.sv
tests/adc_src_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the ADC test-pattern source testbench with Verilator.
# The verdict comes from the simulation log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f list.f \
   --top-module adc_src_tb \
   -o adc_src_sim

./obj_dir/adc_src_sim | tee "$LOG"

if grep -qx "sim passed" "$LOG"; then
   echo "simulation: PASS"
   exit 0
else
   echo "simulation: FAIL"
   exit 1
fi
